/* Makefile */
# Verilator build and run for the dual-clock FIFO testbench
SOURCES := $(wildcard *.sv) flist.f

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vcdc_fifo_tb: $(SOURCES)
	verilator --binary --assert --top-module cdc_fifo_tb -f flist.f

# The log is searched for the failure line; a nonzero simulator status also fails
run: obj_dir/Vcdc_fifo_tb
	./obj_dir/Vcdc_fifo_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "Some tests failed" sim.log; then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* asynchronous_dual_port_ram.sv */
// Dual-clock storage array for the FIFO, one write port and one read port
// Write side clocked by write_clock, registered read side by read_clock
`timescale 1ns/1ns

module asynchronous_dual_port_ram
  import cdc_fifo_pkg::*;
(
  // Write side
  input  logic       write_clock,
  input  logic       write_resetn,
  input  ram_write_t write_port,
  // Read side
  input  logic       read_clock,
  input  logic       read_resetn,
  input  ram_read_t  read_port,
  output data_t      read_data
);

  // Storage array
  data_t memory [FIFO_DEPTH];

  // Write port, array cleared on write reset
  always_ff @(posedge write_clock or negedge write_resetn) begin
    if (!write_resetn) begin
      for (int index = 0; index < FIFO_DEPTH; index++) begin
        memory[index] <= '0;
      end
    end else if (write_port.enable) begin
      memory[write_port.address] <= write_port.data;
    end
  end

  // Read port, output register holds between reads
  always_ff @(posedge read_clock or negedge read_resetn) begin
    if (!read_resetn) begin
      read_data <= '0;
    end else if (read_port.enable) begin
      // Entry was written at least two read edges ago, see empty logic
      read_data <= memory[read_port.address];
    end
  end

endmodule

/* cdc_fifo.sv */
// Top level of the clock-domain-crossing FIFO
// Push side on write_clock, pop side on read_clock, flags are status only
// Joins the RAM, both pointer controllers and the two pointer synchronizers
`timescale 1ns/1ns

module cdc_fifo
  import cdc_fifo_pkg::*;
(
  // Write side
  input  logic  write_clock,
  input  logic  write_resetn,
  input  logic  push,
  input  data_t push_data,
  output logic  full,
  // Read side
  input  logic  read_clock,
  input  logic  read_resetn,
  input  logic  pop,
  output data_t read_data,
  output logic  read_valid,
  output logic  empty
);

  // RAM port requests
  ram_write_t write_port;
  ram_read_t read_port;
  // Gray pointers, local and synchronized
  pointer_t write_gray;
  pointer_t write_gray_sync;
  pointer_t read_gray;
  pointer_t read_gray_sync;

  // Storage
  asynchronous_dual_port_ram ram_inst (
    .write_clock  (write_clock),
    .write_resetn (write_resetn),
    .write_port   (write_port),
    .read_clock   (read_clock),
    .read_resetn  (read_resetn),
    .read_port    (read_port),
    .read_data    (read_data)
  );

  // Write domain
  write_pointer_control write_control_inst (
    .write_clock    (write_clock),
    .write_resetn   (write_resetn),
    .push           (push),
    .push_data      (push_data),
    .read_gray_sync (read_gray_sync),
    .write_port     (write_port),
    .write_gray     (write_gray),
    .full           (full)
  );

  // Read domain
  read_pointer_control read_control_inst (
    .read_clock      (read_clock),
    .read_resetn     (read_resetn),
    .pop             (pop),
    .write_gray_sync (write_gray_sync),
    .read_port       (read_port),
    .read_gray       (read_gray),
    .empty           (empty),
    .read_valid      (read_valid)
  );

  // Write pointer into read_clock
  gray_pointer_sync write_sync_inst (
    .clock       (read_clock),
    .resetn      (read_resetn),
    .pointer_in  (write_gray),
    .pointer_out (write_gray_sync)
  );

  // Read pointer into write_clock
  gray_pointer_sync read_sync_inst (
    .clock       (write_clock),
    .resetn      (write_resetn),
    .pointer_in  (read_gray),
    .pointer_out (read_gray_sync)
  );

endmodule

/* cdc_fifo_pkg.sv */
// Shared widths, depth and types for the dual-clock FIFO
// Imported by every RTL module that carries FIFO words, addresses or pointers
package cdc_fifo_pkg;

  // One FIFO word
  localparam int DATA_WIDTH = 8;
  // Number of RAM entries, power of two only
  localparam int FIFO_DEPTH = 16;
  localparam int ADDRESS_WIDTH = $clog2(FIFO_DEPTH);
  // Address plus wrap bit
  localparam int POINTER_WIDTH = ADDRESS_WIDTH + 1;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDRESS_WIDTH-1:0] address_t;
  // Binary or Gray pointer, same width either way
  typedef logic [POINTER_WIDTH-1:0] pointer_t;

  // RAM write port request, from the write controller
  typedef struct packed {
    logic enable;
    address_t address;
    data_t data;
  } ram_write_t;

  // RAM read port request, from the read controller
  typedef struct packed {
    logic enable;
    address_t address;
  } ram_read_t;

endpackage

/* cdc_fifo_sva.sv */
// Protocol assertions for the dual-clock FIFO, bound onto the top level
// Checks read_valid timing, flag consistency and read-side reset behavior
`timescale 1ns/1ns

module cdc_fifo_sva (
  input logic read_clock,
  input logic read_resetn,
  input logic write_resetn,
  input logic pop,
  input logic empty,
  input logic full,
  input logic read_valid
);

  // read_valid only follows an accepted pop
  assert property (@(posedge read_clock) disable iff (!read_resetn)
    read_valid |-> $past(pop && !empty))
    else $error("read_valid high without an accepted pop one read_clock earlier");

  // Every accepted pop gives read_valid on the next edge
  assert property (@(posedge read_clock) disable iff (!read_resetn)
    (pop && !empty) |=> read_valid)
    else $error("accepted pop not followed by read_valid");

  // Flags are pessimistic but never contradict each other
  assert property (@(posedge read_clock) disable iff (!read_resetn || !write_resetn)
    !(full && empty))
    else $error("full and empty both high");

  // Nothing valid while the read side is in reset
  assert property (@(posedge read_clock) !read_resetn |-> !read_valid)
    else $error("read_valid high during read reset");

endmodule

bind cdc_fifo cdc_fifo_sva cdc_fifo_sva_inst (
  .read_clock   (read_clock),
  .read_resetn  (read_resetn),
  .write_resetn (write_resetn),
  .pop          (pop),
  .empty        (empty),
  .full         (full),
  .read_valid   (read_valid)
);

/* cdc_fifo_tb.sv */
// Testbench for the dual-clock FIFO
// Random push and pop traffic checked against a queue of accepted pushes
// Also covers reset state, fill to full, drain to empty and pointer wrap
`timescale 1ns/1ns

module cdc_fifo_tb
  import cdc_fifo_pkg::*;
();

  localparam logic [31:0] SEED = 32'h55f0;
  // Half periods, 4 ns read and 6 ns write
  localparam int READ_HALF = 2;
  localparam int WRITE_HALF = 3;
  localparam int TRANSFER_WORDS = 200;
  localparam int WRAP_WORDS = 64;
  localparam int EXTRA_PUSHES = 4;
  localparam int EXTRA_POPS = 4;
  // Planned strobes over all phases
  localparam int TOTAL_PUSHES = TRANSFER_WORDS + FIFO_DEPTH + EXTRA_PUSHES + WRAP_WORDS;
  localparam int TOTAL_POPS = 1 + TRANSFER_WORDS + FIFO_DEPTH + EXTRA_POPS + WRAP_WORDS;
  localparam int TIMEOUT_CYCLES = 8 * (TOTAL_PUSHES + TOTAL_POPS) + 200;

  logic write_clock = 1'b0;
  logic write_resetn;
  logic push;
  data_t push_data;
  logic full;
  logic read_clock = 1'b0;
  logic read_resetn;
  logic pop;
  data_t read_data;
  logic read_valid;
  logic empty;

  // Separate random streams per clock domain
  logic [31:0] write_rng;
  logic [31:0] read_rng;
  // Accepted pushes, oldest first
  data_t model_queue[$];
  int valid_count = 0;
  int expected_valids = 0;
  int cycle_count = 0;

  // Odd and even rising edge times, so the two clocks never rise together
  always #(READ_HALF) read_clock = ~read_clock;
  always #(WRITE_HALF) write_clock = ~write_clock;

  cdc_fifo cdc_fifo_inst (
    .write_clock  (write_clock),
    .write_resetn (write_resetn),
    .push         (push),
    .push_data    (push_data),
    .full         (full),
    .read_clock   (read_clock),
    .read_resetn  (read_resetn),
    .pop          (pop),
    .read_data    (read_data),
    .read_valid   (read_valid),
    .empty        (empty)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Oldest word still owed by the FIFO
  function automatic data_t expected_word();
    return model_queue[0];
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // Random pushes until count are accepted, rate is chance in quarters
  task automatic push_words(input int count, input logic [2:0] rate);
    int accepted;
    accepted = 0;
    while (accepted < count) begin
      @(posedge write_clock);
      if (push && !full) accepted++;
      write_rng = lcg_next(write_rng);
      push_data <= data_t'(write_rng >> 16);
      if (accepted < count) push <= ({1'b0, write_rng[29:28]} < rate);
      else push <= 1'b0;
    end
  endtask

  // Random pops until count are accepted
  task automatic pop_words(input int count, input logic [2:0] rate);
    int accepted;
    accepted = 0;
    while (accepted < count) begin
      @(posedge read_clock);
      if (pop && !empty) accepted++;
      read_rng = lcg_next(read_rng);
      if (accepted < count) pop <= ({1'b0, read_rng[29:28]} < rate);
      else pop <= 1'b0;
    end
  endtask

  // Push every cycle, stop after a few pushes dropped while full
  task automatic fill_until_full(output int accepted);
    int dropped;
    accepted = 0;
    dropped = 0;
    @(posedge write_clock);
    write_rng = lcg_next(write_rng);
    push <= 1'b1;
    push_data <= data_t'(write_rng >> 16);
    while (dropped < EXTRA_PUSHES) begin
      @(posedge write_clock);
      if (full) dropped++;
      else accepted++;
      write_rng = lcg_next(write_rng);
      push_data <= data_t'(write_rng >> 16);
      if (dropped == EXTRA_PUSHES) push <= 1'b0;
    end
  endtask

  // Pop every cycle until empty is seen
  task automatic drain_until_empty(output int accepted);
    logic done;
    accepted = 0;
    done = 1'b0;
    @(posedge read_clock);
    pop <= 1'b1;
    while (!done) begin
      @(posedge read_clock);
      if (!empty) begin
        accepted++;
      end else begin
        done = 1'b1;
        pop <= 1'b0;
      end
    end
  endtask

  // Bounded by the timeout counter
  task automatic wait_for_valids(input int target);
    while (valid_count < target) @(negedge read_clock);
  endtask

  // Model records what the DUT accepts
  always @(posedge write_clock) begin
    if (write_resetn && push && !full) model_queue.push_back(push_data);
  end

  // Compare each returned word with the model
  always @(posedge read_clock) begin
    if (read_resetn && read_valid) begin
      if (model_queue.size() == 0) begin
        abort_run("read_valid was high with no accepted push left in the model");
      end else begin
        check_value("read_data", 32'(read_data), 32'(expected_word()));
        void'(model_queue.pop_front());
        valid_count++;
      end
    end
  end

  always @(posedge read_clock) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: run not finished after %0d read_clock cycles",
                          TIMEOUT_CYCLES));
    end
  end

  initial begin
    int accepted;
    write_resetn = 1'b0;
    read_resetn = 1'b0;
    push = 1'b0;
    pop = 1'b0;
    push_data = '0;
    write_rng = SEED;
    read_rng = lcg_next(~SEED);

    // Reset state
    repeat (5) @(posedge read_clock);
    read_resetn <= 1'b1;
    @(posedge write_clock);
    write_resetn <= 1'b1;
    repeat (4) @(negedge read_clock);
    check_value("empty", 32'(empty), 32'd1);
    check_value("full", 32'(full), 32'd0);
    check_value("read_valid", 32'(read_valid), 32'd0);
    check_value("read_data", 32'(read_data), 32'd0);
    // Pop before any push is ignored
    @(posedge read_clock);
    pop <= 1'b1;
    @(posedge read_clock);
    pop <= 1'b0;
    // A wrongly accepted pop would raise read_valid here
    @(negedge read_clock);
    check_value("read_valid", 32'(read_valid), 32'd0);
    check_value("empty", 32'(empty), 32'd1);

    // Ordered transfer with random gaps on both sides
    fork
      push_words(TRANSFER_WORDS, 3'd3);
      pop_words(TRANSFER_WORDS, 3'd2);
    join
    expected_valids += TRANSFER_WORDS;
    wait_for_valids(expected_valids);
    // Every pushed word popped, so the FIFO reads empty
    check_value("empty", 32'(empty), 32'd1);

    // Fill to full, read pointer settled first
    repeat (6) @(posedge write_clock);
    fill_until_full(accepted);
    @(negedge write_clock);
    check_value("accepted_pushes", 32'(accepted), 32'(FIFO_DEPTH));
    check_value("full", 32'(full), 32'd1);

    // Drain to empty
    while (empty) @(posedge read_clock);
    drain_until_empty(accepted);
    check_value("accepted_pops", 32'(accepted), 32'(FIFO_DEPTH));
    expected_valids += FIFO_DEPTH;
    wait_for_valids(expected_valids);
    // Extra pops while empty
    @(posedge read_clock);
    pop <= 1'b1;
    repeat (EXTRA_POPS) @(posedge read_clock);
    pop <= 1'b0;
    repeat (4) @(negedge read_clock);
    check_value("empty", 32'(empty), 32'd1);

    // Wraparound at high rates
    fork
      push_words(WRAP_WORDS, 3'd3);
      pop_words(WRAP_WORDS, 3'd3);
    join
    expected_valids += WRAP_WORDS;
    wait_for_valids(expected_valids);
    check_value("empty", 32'(empty), 32'd1);

    $display("All tests passed");
    $finish;
  end

endmodule

/* flist.f */
cdc_fifo_pkg.sv
asynchronous_dual_port_ram.sv
gray_pointer_sync.sv
write_pointer_control.sv
read_pointer_control.sv
cdc_fifo.sv
cdc_fifo_sva.sv
cdc_fifo_tb.sv

/* gray_pointer_sync.sv */
// Two-flop synchronizer carrying a Gray-coded pointer into another clock domain
// Instantiated once per crossing direction in the FIFO top level
`timescale 1ns/1ns

module gray_pointer_sync
  import cdc_fifo_pkg::*;
(
  // Destination domain clock and reset
  input  logic     clock,
  input  logic     resetn,
  // Gray pointer from the source domain
  input  pointer_t pointer_in,
  // Synchronized copy, two edges late
  output pointer_t pointer_out
);

  // First stage, may go metastable
  pointer_t meta_stage;
  // Second stage, settled value
  pointer_t stable_stage;

  // Only one bit moves per source edge, so the sample is old or new
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      meta_stage   <= '0;
      stable_stage <= '0;
    end else begin
      meta_stage   <= pointer_in;
      stable_stage <= meta_stage;
    end
  end

  assign pointer_out = stable_stage;

endmodule

/* read_pointer_control.sv */
// Read-domain pointer logic of the FIFO
// Accepts pop strobes, drives the RAM read port, registers empty and read_valid
// Empty compares against the write pointer synchronized into read_clock
`timescale 1ns/1ns

module read_pointer_control
  import cdc_fifo_pkg::*;
(
  input  logic      read_clock,
  input  logic      read_resetn,
  // Pop strobe
  input  logic      pop,
  // Write Gray pointer, already synchronized
  input  pointer_t  write_gray_sync,
  // RAM read request
  output ram_read_t read_port,
  // Gray pointer towards the write domain
  output pointer_t  read_gray,
  output logic      empty,
  // High one cycle after an accepted pop
  output logic      read_valid
);

  pointer_t read_binary;
  pointer_t read_binary_next;
  pointer_t read_gray_next;
  logic pop_accept;

  // Pop while empty is ignored
  assign pop_accept = pop && !empty;

  // Advance by one on an accepted pop
  assign read_binary_next = read_binary + pointer_t'(pop_accept);
  // Binary to Gray
  assign read_gray_next = (read_binary_next >> 1) ^ read_binary_next;

  // Pointer, flag and valid registers
  always_ff @(posedge read_clock or negedge read_resetn) begin
    if (!read_resetn) begin
      read_binary <= '0;
      read_gray   <= '0;
      // Nothing stored after reset
      empty       <= 1'b1;
      read_valid  <= 1'b0;
    end else begin
      read_binary <= read_binary_next;
      read_gray   <= read_gray_next;
      // Set on the pop of the last known entry
      empty       <= (read_gray_next == write_gray_sync);
      // Lines up with the RAM output register
      read_valid  <= pop_accept;
    end
  end

  // RAM read request for the accepted pop, wrap bit dropped
  assign read_port.enable  = pop_accept;
  assign read_port.address = read_binary[ADDRESS_WIDTH-1:0];

endmodule

/* write_pointer_control.sv */
// Write-domain pointer logic of the FIFO
// Accepts push strobes, drives the RAM write port and registers the full flag
// Full compares against the read pointer synchronized into write_clock
`timescale 1ns/1ns

module write_pointer_control
  import cdc_fifo_pkg::*;
(
  input  logic       write_clock,
  input  logic       write_resetn,
  // Push strobe and its word
  input  logic       push,
  input  data_t      push_data,
  // Read Gray pointer, already synchronized
  input  pointer_t   read_gray_sync,
  // RAM write request
  output ram_write_t write_port,
  // Gray pointer towards the read domain
  output pointer_t   write_gray,
  output logic       full
);

  pointer_t write_binary;
  pointer_t write_binary_next;
  pointer_t write_gray_next;
  // Read pointer as it looks when the FIFO is full
  pointer_t full_compare;
  logic push_accept;

  // Push while full is dropped
  assign push_accept = push && !full;

  // Advance by one on an accepted push
  assign write_binary_next = write_binary + pointer_t'(push_accept);
  // Binary to Gray
  assign write_gray_next = (write_binary_next >> 1) ^ write_binary_next;

  // Full when pointers differ only in the top two Gray bits
  assign full_compare = {~read_gray_sync[POINTER_WIDTH-1:POINTER_WIDTH-2],
                         read_gray_sync[POINTER_WIDTH-3:0]};

  // Pointer and flag registers
  always_ff @(posedge write_clock or negedge write_resetn) begin
    if (!write_resetn) begin
      write_binary <= '0;
      write_gray   <= '0;
      full         <= 1'b0;
    end else begin
      write_binary <= write_binary_next;
      write_gray   <= write_gray_next;
      // Set on the push that fills the last entry
      full         <= (write_gray_next == full_compare);
    end
  end

  // RAM write request for the accepted push, wrap bit dropped
  assign write_port.enable  = push_accept;
  assign write_port.address = write_binary[ADDRESS_WIDTH-1:0];
  assign write_port.data    = push_data;

endmodule
